//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_lane_cdc \
		-Mdir obj_dir -o tb_lane_cdc

run: compile
	./obj_dir/tb_lane_cdc | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cdc_cfg_pkg.sv
// Fixed widths and default sizes for the multi-lane CDC; imported by the types package and top.
`default_nettype none

package cdc_cfg_pkg;

    // payload width of one beat in bits.
    localparam int data_width = 8;

    // the source flags the last beat of each frame of this many beats.
    localparam int frame_len = 16;

    // default number of parallel FIFO lanes.
    localparam int default_lanes = 4;

    // default lane FIFO depth as a power of two where 4 means 16 entries.
    localparam int default_addr_width = 4;

    // default number of beats that may be outstanding at the output.
    localparam int default_credits = 4;

endpackage

`default_nettype wire

//--- cdc_lane.sv
// One CDC lane that drains its gray FIFO through a settle and stream FSM into a holding register.
`timescale 1ns/1ps
`default_nettype none

module cdc_lane import cdc_types_pkg::*; #(
    parameter int addr_width
) (
    input  wire        wr_clk,
    input  wire        rst,
    input  wire        wr_en,
    input  wire beat_t wr_beat,
    output logic       full,
    input  wire        rd_clk,
    output logic       valid,
    output beat_t      beat,
    input  wire        take
);

    localparam logic [1:0] st_start  = 2'd0;
    localparam logic [1:0] st_settle = 2'd1;
    localparam logic [1:0] st_stream = 2'd2;

    logic [1:0] state;
    logic [2:0] empty_hist;
    logic       fifo_empty;
    logic       fifo_rd_en;
    beat_t      fifo_rd_beat;
    logic       rd_pending;
    logic       hold_valid;
    beat_t      hold_beat;

    gray_async_fifo #(
        .addr_width(addr_width)
    ) gray_async_fifo_inst (
        .wr_clk (wr_clk),
        .rst    (rst),
        .wr_en  (wr_en),
        .wr_beat(wr_beat),
        .full   (full),
        .rd_clk (rd_clk),
        .rd_en  (fifo_rd_en),
        .rd_beat(fifo_rd_beat),
        .empty  (fifo_empty)
    );

    // one read in flight at a time, and only into a register that will be free.
    assign fifo_rd_en = (state == st_stream) && !fifo_empty && !rd_pending
                        && (!hold_valid || take);

    always_ff @(posedge rd_clk or posedge rst) begin
        if (rst) begin
            state      <= st_start;
            empty_hist <= 3'b111;
            rd_pending <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            empty_hist <= {empty_hist[1:0], fifo_empty};
            rd_pending <= fifo_rd_en;
            if (rd_pending) begin
                hold_valid <= 1'b1;
            end else if (take) begin
                hold_valid <= 1'b0;
            end
            case (state)
                st_start:  state <= st_settle;
                st_settle: begin
                    // stream only once empty has been low for three samples running.
                    if (empty_hist == 3'b000) begin
                        state <= st_stream;
                    end
                end
                st_stream: begin
                    if (fifo_empty && !rd_pending && !hold_valid) begin
                        state <= st_settle;
                    end
                end
                default:   state <= st_start;
            endcase
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_pending) begin
            hold_beat <= fifo_rd_beat;
        end
    end

    assign valid = hold_valid;
    assign beat  = hold_beat;

endmodule

`default_nettype wire

//--- cdc_types_pkg.sv
// Beat type carried through the distributor, the lane FIFOs and the merger.
`default_nettype none

package cdc_types_pkg;

    import cdc_cfg_pkg::*;

    // one data beat as it moves through every stage of the design.
    // frame_end sits in the low bit so the payload reads as the upper byte
    // of the packed word when viewed in a waveform.
    typedef struct packed {
        logic [data_width-1:0] payload;
        logic                  frame_end;
    } beat_t;

endpackage

`default_nettype wire

//--- gray_async_fifo.sv
// Dual-clock FIFO with gray-coded pointers, used as the storage of each CDC lane.
`timescale 1ns/1ps
`default_nettype none

module gray_async_fifo import cdc_types_pkg::*; #(
    parameter int addr_width
) (
    input  wire        wr_clk,
    input  wire        rst,
    input  wire        wr_en,
    input  wire beat_t wr_beat,
    output logic       full,
    input  wire        rd_clk,
    input  wire        rd_en,
    output beat_t      rd_beat,
    output logic       empty
);

    localparam int depth = 1 << addr_width;

    // a full pointer differs from the read pointer in its two top gray bits.
    localparam logic [addr_width:0] full_mask = (addr_width + 1)'(3) << (addr_width - 1);

    beat_t mem [depth];

    logic [addr_width:0] wr_bin;
    logic [addr_width:0] wr_gray;
    logic [addr_width:0] wr_bin_next;
    logic [addr_width:0] wr_gray_next;
    logic [addr_width:0] rd_bin;
    logic [addr_width:0] rd_gray;
    logic [addr_width:0] rd_bin_next;
    logic [addr_width:0] rd_gray_next;

    // gray pointers after the two-flop synchronizers.
    logic [addr_width:0] rd_gray_w1;
    logic [addr_width:0] rd_gray_w2;
    logic [addr_width:0] wr_gray_r1;
    logic [addr_width:0] wr_gray_r2;

    logic wr_fire;
    logic rd_fire;

    assign wr_fire      = wr_en && !full;
    assign rd_fire      = rd_en && !empty;
    assign wr_bin_next  = wr_bin + {{addr_width{1'b0}}, wr_fire};
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
    assign rd_bin_next  = rd_bin + {{addr_width{1'b0}}, rd_fire};
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[addr_width-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge wr_clk or posedge rst) begin
        if (rst) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
            full       <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
            // the synchronized read pointer is stale, so full may linger a few cycles.
            full       <= (wr_gray_next == (rd_gray_w2 ^ full_mask));
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_fire) begin
            rd_beat <= mem[rd_bin[addr_width-1:0]];
        end
    end

    always_ff @(posedge rd_clk or posedge rst) begin
        if (rst) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
            empty      <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
            // new writes show up here only after they pass the synchronizer.
            empty      <= (rd_gray_next == wr_gray_r2);
        end
    end

endmodule

`default_nettype wire

//--- lane_cdc_top.sv
// Top level of the multi-lane CDC that the testbench or a larger system instantiates.
`timescale 1ns/1ps
`default_nettype none

module lane_cdc_top import cdc_cfg_pkg::*, cdc_types_pkg::*; #(
    parameter int lanes      = default_lanes,
    parameter int addr_width = default_addr_width,
    parameter int credits    = default_credits
) (
    input  wire        wr_clk,
    input  wire        rd_clk,
    input  wire        rst,
    input  wire        in_valid,
    input  wire beat_t in_beat,
    output logic       in_ready,
    output logic       out_valid,
    output beat_t      out_beat,
    input  wire        credit_return
);

    logic  [lanes-1:0] lane_wr_en;
    logic  [lanes-1:0] lane_full;
    beat_t             lane_wr_beat;
    logic  [lanes-1:0] lane_valid;
    logic  [lanes-1:0] lane_take;
    beat_t [lanes-1:0] lane_beat;

    lane_distributor #(
        .lanes(lanes)
    ) lane_distributor_inst (
        .wr_clk      (wr_clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .in_ready    (in_ready),
        .lane_full   (lane_full),
        .lane_wr_en  (lane_wr_en),
        .lane_wr_beat(lane_wr_beat)
    );

    for (genvar k = 0; k < lanes; k++) begin : g_lane
        cdc_lane #(
            .addr_width(addr_width)
        ) cdc_lane_inst (
            .wr_clk (wr_clk),
            .rst    (rst),
            .wr_en  (lane_wr_en[k]),
            .wr_beat(lane_wr_beat),
            .full   (lane_full[k]),
            .rd_clk (rd_clk),
            .valid  (lane_valid[k]),
            .beat   (lane_beat[k]),
            .take   (lane_take[k])
        );
    end

    lane_merger #(
        .lanes  (lanes),
        .credits(credits)
    ) lane_merger_inst (
        .rd_clk       (rd_clk),
        .rst          (rst),
        .lane_valid   (lane_valid),
        .lane_beat    (lane_beat),
        .lane_take    (lane_take),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .credit_return(credit_return)
    );

endmodule

`default_nettype wire

//--- lane_distributor.sv
// Write-domain round-robin steering of input beats across the CDC lanes.
`timescale 1ns/1ps
`default_nettype none

module lane_distributor import cdc_types_pkg::*; #(
    parameter int lanes
) (
    input  wire              wr_clk,
    input  wire              rst,
    input  wire              in_valid,
    input  wire beat_t       in_beat,
    output logic             in_ready,
    input  wire  [lanes-1:0] lane_full,
    output logic [lanes-1:0] lane_wr_en,
    output beat_t            lane_wr_beat
);

    localparam int ptr_width = (lanes > 1) ? $clog2(lanes) : 1;

    logic [ptr_width-1:0] ptr;
    logic                 accept;

    // a write still queued for the pointed lane is not yet seen in its full flag.
    assign in_ready = !lane_full[ptr] && !lane_wr_en[ptr];
    assign accept   = in_valid && in_ready;

    always_ff @(posedge wr_clk or posedge rst) begin
        if (rst) begin
            ptr        <= '0;
            lane_wr_en <= '0;
        end else begin
            for (int k = 0; k < lanes; k++) begin
                lane_wr_en[k] <= accept && (ptr == ptr_width'(k));
            end
            if (accept) begin
                if (ptr == ptr_width'(lanes - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (accept) begin
            lane_wr_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

//--- lane_merger.sv
// Read-domain round-robin collection from the lanes with a credit-limited registered output.
`timescale 1ns/1ps
`default_nettype none

module lane_merger import cdc_types_pkg::*; #(
    parameter int lanes,
    parameter int credits
) (
    input  wire                    rd_clk,
    input  wire                    rst,
    input  wire        [lanes-1:0] lane_valid,
    input  wire beat_t [lanes-1:0] lane_beat,
    output logic       [lanes-1:0] lane_take,
    output logic                   out_valid,
    output beat_t                  out_beat,
    input  wire                    credit_return
);

    localparam int ptr_width = (lanes > 1) ? $clog2(lanes) : 1;
    localparam int cnt_width = $clog2(credits + 1);

    logic [ptr_width-1:0] ptr;
    logic [cnt_width-1:0] credit_cnt;
    logic                 send;

    // waiting on the expected lane alone keeps the stream in its original order.
    assign send = lane_valid[ptr] && (credit_cnt != '0);

    always_comb begin
        lane_take      = '0;
        lane_take[ptr] = send;
    end

    always_ff @(posedge rd_clk or posedge rst) begin
        if (rst) begin
            ptr        <= '0;
            credit_cnt <= cnt_width'(credits);
            out_valid  <= 1'b0;
        end else begin
            out_valid <= send;
            if (send) begin
                if (ptr == ptr_width'(lanes - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
            if (send && !credit_return) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (!send && credit_return && credit_cnt != cnt_width'(credits)) begin
                // a surplus credit beyond the limit is dropped.
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (send) begin
            out_beat <= lane_beat[ptr];
        end
    end

endmodule

`default_nettype wire

//--- tb.f
cdc_cfg_pkg.sv
cdc_types_pkg.sv
gray_async_fifo.sv
cdc_lane.sv
lane_distributor.sv
lane_merger.sv
lane_cdc_top.sv
tb_lane_cdc.sv

//--- tb_lane_cdc.sv
// Testbench for the multi-lane CDC with a random source, a credit-returning sink and a reference model.
`timescale 1ns/1ps
`default_nettype none

module tb_lane_cdc import cdc_cfg_pkg::*, cdc_types_pkg::*; ;

    localparam int lanes      = default_lanes;
    localparam int addr_width = default_addr_width;
    localparam int credits    = default_credits;

    logic  wr_clk        = 1'b0;
    logic  rd_clk        = 1'b0;
    logic  rst           = 1'b1;
    logic  in_valid      = 1'b0;
    beat_t in_beat       = '0;
    logic  credit_return = 1'b0;
    logic  in_ready;
    logic  out_valid;
    beat_t out_beat;

    logic [31:0] src_rng       = 32'hdc9;
    logic [31:0] snk_rng       = 32'hdc9 * 32'd1103515245 + 32'd12345;
    logic        hold_credits  = 1'b0;
    logic        saw_not_ready = 1'b0;
    int          src_idx       = 0;
    int          rcv_idx       = 0;
    int          outstanding   = 0;

    always #5 rd_clk = ~rd_clk;
    always #7 wr_clk = ~wr_clk;

    lane_cdc_top #(
        .lanes     (lanes),
        .addr_width(addr_width),
        .credits   (credits)
    ) lane_cdc_top_inst (
        .wr_clk       (wr_clk),
        .rd_clk       (rd_clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .credit_return(credit_return)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // beat number idx of the stream, as sent by the source and expected at the output.
    function automatic beat_t expected_beat(input int idx);
        logic [31:0] hash;
        beat_t       b;
        hash        = 32'(idx) * 32'd1664525 + 32'd1013904223;
        b.payload   = hash[data_width-1:0];
        b.frame_end = (idx % frame_len) == (frame_len - 1);
        return b;
    endfunction

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t: %s", $time, what);
        stop_with_failure();
    endtask

    task automatic apply_reset();
        @(negedge rd_clk);
        rst      = 1'b1;
        in_valid = 1'b0;
        src_idx  = 0;
        repeat (8) @(negedge rd_clk);
        rst = 1'b0;
    endtask

    // sends count beats with a random idle gap of up to max_gap wr_clk cycles before each.
    task automatic send_stream(input int count, input int max_gap);
        int gap;
        int waited;
        @(negedge wr_clk);
        for (int n = 0; n < count; n++) begin
            src_rng = lcg_next(src_rng);
            gap     = int'(src_rng[23:16]) % (max_gap + 1);
            repeat (gap) @(negedge wr_clk);
            in_valid = 1'b1;
            in_beat  = expected_beat(src_idx);
            waited   = 0;
            // in_ready only changes on a rising wr_clk edge, so this value is what gets sampled.
            while (!in_ready) begin
                saw_not_ready = 1'b1;
                @(negedge wr_clk);
                waited++;
                if (waited > 2000) begin
                    report_timeout("in_ready stayed low for too long");
                end
            end
            @(negedge wr_clk);
            in_valid = 1'b0;
            src_idx++;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (rcv_idx != src_idx) begin
            @(negedge rd_clk);
            waited++;
            if (waited > 5000) begin
                report_timeout("not every sent beat arrived at the output");
            end
        end
    endtask

    // output checker and credit-returning sink, both working on the falling rd_clk edge.
    always @(negedge rd_clk) begin
        if (rst) begin
            rcv_idx       = 0;
            outstanding   = 0;
            credit_return = 1'b0;
        end else begin
            if (out_valid) begin
                check_value("credit_in_use_below_limit", 32'(outstanding < credits), 32'd1);
                check_value("out_beat", 32'(out_beat), 32'(expected_beat(rcv_idx)));
                rcv_idx++;
                outstanding++;
            end
            snk_rng       = lcg_next(snk_rng);
            credit_return = (outstanding > 0) && !hold_credits && (snk_rng[17:16] != 2'b00);
            if (credit_return) begin
                outstanding--;
            end
        end
    end

    initial begin
        apply_reset();

        // ordered stream across all lanes with a prompt sink.
        send_stream(400, 3);
        wait_drained();

        // credits withheld long enough for the lane FIFOs to fill up.
        saw_not_ready = 1'b0;
        fork
            begin
                hold_credits = 1'b1;
                repeat (300) @(negedge rd_clk);
                check_value("in_ready_low_seen", 32'(saw_not_ready), 32'd1);
                hold_credits = 1'b0;
            end
            send_stream(200, 1);
        join
        wait_drained();

        // single beats with long idle time, so each lane drops back to settle.
        for (int t = 0; t < 6; t++) begin
            send_stream(1, 0);
            wait_drained();
            repeat (80) @(negedge rd_clk);
        end

        // reset while beats are still in the lanes.
        send_stream(40, 0);
        apply_reset();
        repeat (50) @(negedge rd_clk);
        check_value("rcv_idx", 32'(rcv_idx), 32'd0);
        send_stream(120, 2);
        wait_drained();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
